// File: project.f
source/socPkg.sv
source/busFabric.sv
source/ramSlave.sv
source/gpioSlave.sv
source/socTop.sv
tests/tbClock.sv
tests/socTopTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, then scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module socTopTb -f project.f -o socTopSim

./obj_dir/socTopSim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished cleanly"

// File: source/busFabric.sv
`timescale 1ns/1ps

module busFabric import socPkg::*; (
    input  logic  HCLK,     // bus clock
    input  logic  rstN,     // async reset, active low
    input  wbReqT busReq,   // from external master
    output wbRspT busRsp,   // back to master
    output wbReqT ramReq,   // to data ram
    input  wbRspT ramRsp,
    output wbReqT gpioReq,  // to gpio block
    input  wbRspT gpioRsp
);

    slaveSelT slaveSel;  // decoded target
    logic     nomapAck;  // ack from unmapped responder

    ////////////////////////////////////////////////////////////
    // address decoder
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (busReq.adr[31:24])
            regionRam:  slaveSel = selRam;
            regionGpio: slaveSel = selGpio;
            default:    slaveSel = selNone;  // nobody claims it
        endcase
    end

    ////////////////////////////////////////////////////////////
    // request routing
    ////////////////////////////////////////////////////////////

    // every slave sees the full request, only the target gets stb
    always_comb begin
        ramReq      = busReq;
        ramReq.stb  = busReq.stb & (slaveSel == selRam);
        gpioReq     = busReq;
        gpioReq.stb = busReq.stb & (slaveSel == selGpio);
    end

    ////////////////////////////////////////////////////////////
    // unmapped responder
    ////////////////////////////////////////////////////////////

    // same two-edge timing as the real slaves, writes dropped
    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            nomapAck <= 1'b0;
        end else begin
            nomapAck <= busReq.cyc & busReq.stb & (slaveSel == selNone) & ~nomapAck;
        end
    end

    ////////////////////////////////////////////////////////////
    // response multiplexer
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (slaveSel)
            selRam:  busRsp = ramRsp;
            selGpio: busRsp = gpioRsp;
            default: begin
                busRsp.datR = badData;   // fixed pattern
                busRsp.ack  = nomapAck;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////////////////////////

    // decoder must never let two targets answer together
    ackOneHot: assert property (
        @(posedge HCLK) disable iff (!rstN)
        $onehot0({ramRsp.ack, gpioRsp.ack, nomapAck})
    ) else $error("more than one slave acknowledged in the same cycle");

    // an ack only shows up inside a bus cycle
    ackInCycle: assert property (
        @(posedge HCLK) disable iff (!rstN)
        $rose(busRsp.ack) |-> busReq.cyc
    ) else $error("busRsp.ack rose while cyc was low");

endmodule

// File: source/gpioSlave.sv
`timescale 1ns/1ps

module gpioSlave import socPkg::*; (
    input  logic                   HCLK,     // bus clock
    input  logic                   rstN,     // async reset, active low
    input  wbReqT                  gpioReq,  // strobe already gated by fabric
    output wbRspT                  gpioRsp,
    input  logic [ledWidth-1:0]    sw,       // slide switches, async
    input  logic [buttonWidth-1:0] buttons,  // pushbuttons, async
    output logic [ledWidth-1:0]    led       // led drive
);

    // register offsets, adr[3:2]
    localparam logic [1:0] offLed    = 2'd0;  // 0x0
    localparam logic [1:0] offSw     = 2'd2;  // 0x8
    localparam logic [1:0] offButton = 2'd3;  // 0xC

    logic [ledWidth-1:0]    swMeta, swSync;    // switch synchronizer
    logic [buttonWidth-1:0] btnMeta, btnSync;  // button synchronizer
    logic                   ackQ;
    logic                   access;            // new transfer this edge
    busDataT                rdData;
    busDataT                rdNext;            // selected register

    assign access = gpioReq.cyc & gpioReq.stb & ~ackQ;

    ////////////////////////////////////////////////////////////
    // input synchronizers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            swMeta  <= '0;
            swSync  <= '0;
            btnMeta <= '0;
            btnSync <= '0;
        end else begin
            swMeta  <= sw;       // first flop may go metastable
            swSync  <= swMeta;
            btnMeta <= buttons;
            btnSync <= btnMeta;
        end
    end

    ////////////////////////////////////////////////////////////
    // led register and acknowledge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            led  <= '0;
            ackQ <= 1'b0;
        end else begin
            ackQ <= access;
            if (access && gpioReq.we && gpioReq.adr[3:2] == offLed) begin
                for (int b = 0; b < ledWidth / 8; b++) begin
                    if (gpioReq.sel[b]) begin
                        led[8*b +: 8] <= gpioReq.datW[8*b +: 8];  // low lanes only
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (gpioReq.adr[3:2])
            offLed:    rdNext = busDataT'(led);
            offSw:     rdNext = busDataT'(swSync);
            offButton: rdNext = busDataT'(btnSync);  // zero-extended
            default:   rdNext = '0;                  // offset 4 is empty
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (access && !gpioReq.we) begin
            rdData <= rdNext;
        end
    end

    assign gpioRsp.datR = rdData;
    assign gpioRsp.ack  = ackQ;

endmodule

// File: source/ramSlave.sv
`timescale 1ns/1ps

module ramSlave import socPkg::*; #(
    parameter int ramWords = 1024  // depth in words, power of two
) (
    input  logic  HCLK,    // bus clock
    input  logic  rstN,    // async reset, active low
    input  wbReqT ramReq,  // strobe already gated by fabric
    output wbRspT ramRsp
);

    localparam int idxWidth = $clog2(ramWords);  // word index bits

    busDataT               mem [ramWords];  // storage
    busDataT               rdData;          // registered read word
    logic                  ackQ;            // acknowledge flop
    logic                  access;          // new transfer this edge
    logic [idxWidth-1:0]   wordIdx;         // word address, wraps

    ////////////////////////////////////////////////////////////
    // access decode
    ////////////////////////////////////////////////////////////

    assign access  = ramReq.cyc & ramReq.stb & ~ackQ;  // first edge with stb
    assign wordIdx = ramReq.adr[idxWidth+1:2];          // drop byte offset

    ////////////////////////////////////////////////////////////
    // memory array
    ////////////////////////////////////////////////////////////

    always_ff @(posedge HCLK) begin
        if (access && ramReq.we) begin
            for (int b = 0; b < 4; b++) begin
                if (ramReq.sel[b]) begin
                    mem[wordIdx][8*b +: 8] <= ramReq.datW[8*b +: 8];  // lane write
                end
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (access && !ramReq.we) begin
            rdData <= mem[wordIdx];  // ready with ack
        end
    end

    ////////////////////////////////////////////////////////////
    // acknowledge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            ackQ <= 1'b0;
        end else begin
            ackQ <= access;  // high for one cycle
        end
    end

    assign ramRsp.datR = rdData;
    assign ramRsp.ack  = ackQ;

    // a held stb restarts the transfer, it never stretches ack
    ackPulse: assert property (
        @(posedge HCLK) disable iff (!rstN)
        ackQ |=> !ackQ
    ) else $error("ram ack stayed high for two cycles");

endmodule

// File: source/socPkg.sv
package socPkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] busAddrT;  // byte address
    typedef logic [31:0] busDataT;  // data word
    typedef logic [3:0]  byteSelT;  // one enable per byte lane

    ////////////////////////////////////////////////////////////
    // wishbone classic request and response
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic    cyc;   // bus cycle in progress
        logic    stb;   // transfer strobe
        logic    we;    // write when high
        busAddrT adr;   // byte address
        busDataT datW;  // write data
        byteSelT sel;   // byte lanes
    } wbReqT;           // master to slave, 71 bits

    typedef struct packed {
        busDataT datR;  // read data, valid with ack
        logic    ack;   // one-cycle acknowledge
    } wbRspT;           // slave to master, 33 bits

    // target of the current address
    typedef enum logic [1:0] {
        selRam,
        selGpio,
        selNone
    } slaveSelT;

    ////////////////////////////////////////////////////////////
    // address map, adr[31:24]
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] regionRam  = 8'h20;  // data ram
    localparam logic [7:0] regionGpio = 8'h50;  // leds, switches, buttons

    localparam busDataT badData = 32'hdeadbeef;  // read from unmapped space

    // board i/o widths
    localparam int ledWidth    = 16;  // leds and slide switches
    localparam int buttonWidth = 5;   // pushbuttons

endpackage

// File: source/socTop.sv
`timescale 1ns/1ps

module socTop import socPkg::*; #(
    parameter int ramWords = 1024  // ram depth in words
) (
    input  logic                   HCLK,     // system bus clock
    input  logic                   rstN,     // async reset, active low
    input  wbReqT                  busReq,   // external master port
    output wbRspT                  busRsp,
    input  logic [ledWidth-1:0]    sw,       // slide switches
    input  logic [buttonWidth-1:0] buttons,  // pushbuttons
    output logic [ledWidth-1:0]    led       // leds above the switches
);

    ////////////////////////////////////////////////////////////
    // slave side of the fabric
    ////////////////////////////////////////////////////////////

    wbReqT ramReq, gpioReq;   // gated requests
    wbRspT ramRsp, gpioRsp;   // slave answers

    busFabric u_busFabric (
        .HCLK    (HCLK),
        .rstN    (rstN),
        .busReq  (busReq),   // from master
        .busRsp  (busRsp),   // muxed answer
        .ramReq  (ramReq),
        .ramRsp  (ramRsp),
        .gpioReq (gpioReq),
        .gpioRsp (gpioRsp)
    );

    // data memory, region 0x20
    ramSlave #(
        .ramWords (ramWords)
    ) u_ramSlave (
        .HCLK   (HCLK),
        .rstN   (rstN),
        .ramReq (ramReq),
        .ramRsp (ramRsp)
    );

    // board i/o, region 0x50
    gpioSlave u_gpioSlave (
        .HCLK    (HCLK),
        .rstN    (rstN),
        .gpioReq (gpioReq),
        .gpioRsp (gpioRsp),
        .sw      (sw),
        .buttons (buttons),
        .led     (led)
    );

endmodule

// File: tests/socTopTb.sv
`timescale 1ns/1ps

module socTopTb import socPkg::*; ();

    localparam int clkPeriod   = 4;     // ns
    localparam int resetCycles = 3;
    localparam int ramWords    = 1024;  // handed down to the ram
    localparam int ackLimit    = 8;     // cycles before an access gives up
    localparam int initWrites  = 8;     // full words, read back later
    localparam int mergeWrites = 16;    // random sel on top
    localparam int wrapWords   = 4;
    localparam int inputRounds = 3;
    localparam int numTransfers = 2 * initWrites + mergeWrites + 2 * wrapWords + 7
                                + 2 * inputRounds + 6;
    localparam int watchdogCycles = 10 * numTransfers + resetCycles;

    logic HCLK, rstN;
    wbReqT busReq;
    wbRspT busRsp;
    logic [ledWidth-1:0] sw, led, expLed;
    logic [buttonWidth-1:0] buttons;
    busDataT ramModel [ramWords];  // byte-merged contents
    busDataT expData;              // expected read word
    logic readCheck;               // current access is a read
    int stbEdges;                  // edges with stb and no ack yet
    int seed, failCount, timingFails, testsPassed, testsFailed, transfers;

    tbClock #(.period(clkPeriod), .resetCycles(resetCycles)) u_tbClock (
        .HCLK (HCLK),
        .rstN (rstN)
    );

    socTop #(.ramWords(ramWords)) u_socTop (
        .HCLK    (HCLK),
        .rstN    (rstN),
        .busReq  (busReq),
        .busRsp  (busRsp),
        .sw      (sw),
        .buttons (buttons),
        .led     (led)
    );

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            stbEdges <= 0;
        end else if (busReq.cyc && busReq.stb && !busRsp.ack) begin
            stbEdges <= stbEdges + 1;  // waiting on the slave
        end else begin
            stbEdges <= 0;
        end
    end

    readValue: assert property (@(posedge HCLK) disable iff (!rstN)
        (readCheck && busRsp.ack) |-> busRsp.datR == expData
    ) else begin
        $display("[FAIL] %0t busRsp.datR at %h: expected %h, got %h", $time,
                 $sampled(busReq.adr), $sampled(expData), $sampled(busRsp.datR));
        failCount++;
    end

    ledValue: assert property (@(posedge HCLK) disable iff (!rstN)
        !busReq.cyc |-> led == expLed  // bus idle, write has landed
    ) else begin
        $display("[FAIL] %0t led: expected %h, got %h", $time, $sampled(expLed), $sampled(led));
        failCount++;
    end

    // ack on the second edge that sees stb
    ackOnTime: assert property (@(posedge HCLK) disable iff (!rstN)
        busRsp.ack |-> (busReq.cyc && busReq.stb && stbEdges == 1)
    ) else begin
        $display("acknowledge at %0t did not come two edges after the strobe", $time);
        timingFails++;
        failCount++;
    end

    ackNotLate: assert property (@(posedge HCLK) disable iff (!rstN)
        (busReq.cyc && busReq.stb && !busRsp.ack) |-> stbEdges == 0
    ) else begin
        $display("the slave missed its acknowledge edge at %0t", $time);
        timingFails++;
        failCount++;
    end

    ackOneCycle: assert property (@(posedge HCLK) disable iff (!rstN)
        busRsp.ack |=> !busRsp.ack
    ) else begin
        $display("acknowledge stayed high for more than one cycle at %0t", $time);
        timingFails++;
        failCount++;
    end

    ////////////////////////////////////////////////////////////
    // bus master and model helpers
    ////////////////////////////////////////////////////////////

    function automatic busDataT mergeBytes(busDataT oldWord, busDataT newWord, byteSelT sel);
        busDataT merged;
        merged = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return merged;
    endfunction

    function automatic busAddrT ramAddr(int idx);
        return {regionRam, 24'(idx * 4)};  // bits above the index are ignored
    endfunction

    function automatic busAddrT gpioAddr(logic [3:0] offset);
        return {regionGpio, 20'd0, offset};
    endfunction

    task automatic busAccess(input logic we, input busAddrT adr, input busDataT datW,
                             input byteSelT sel, input busDataT expRead);
        int waited;
        @(posedge HCLK);
        busReq    <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datW: datW, sel: sel};
        readCheck <= ~we;
        expData   <= expRead;
        transfers++;
        waited = 0;
        do begin
            @(negedge HCLK);  // ack is stable mid-cycle
            waited++;
        end while (!busRsp.ack && waited < ackLimit);
        if (!busRsp.ack) begin
            $display("no acknowledge for the access to %h after %0d cycles", adr, ackLimit);
            failCount++;
        end
        @(posedge HCLK);      // edge where the master takes ack
        busReq    <= '0;
        readCheck <= 1'b0;
    endtask

    task automatic writeWord(input busAddrT adr, input busDataT datW, input byteSelT sel);
        busAccess(1'b1, adr, datW, sel, '0);
    endtask

    task automatic readWord(input busAddrT adr, input busDataT expRead);
        busAccess(1'b0, adr, '0, 4'hf, expRead);
    endtask

    task automatic finishTest(input string name, input int failsBefore);
        repeat (2) @(posedge HCLK);
        @(negedge HCLK);  // late assertion reports land first
        if (failCount == failsBefore) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, failCount - failsBefore);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int failsBefore, idx;
        int ramIdx [initWrites];
        busDataT word;
        byteSelT sel;
        logic [ledWidth-1:0] swVal, newLed;
        logic [buttonWidth-1:0] btnVal;
        seed = 86;
        failCount = 0;
        timingFails = 0;
        testsPassed = 0;
        testsFailed = 0;
        transfers = 0;
        busReq    <= '0;
        sw        <= '0;
        buttons   <= '0;
        readCheck <= 1'b0;
        expData   <= '0;
        expLed    <= '0;  // led comes out of reset at zero
        wait (rstN === 1'b1);

        failsBefore = failCount;
        for (int i = 0; i < initWrites; i++) begin
            ramIdx[i] = int'($unsigned($random(seed)) % ramWords);
            word = $random(seed);
            ramModel[ramIdx[i]] = word;
            writeWord(ramAddr(ramIdx[i]), word, 4'hf);
        end
        for (int i = 0; i < mergeWrites; i++) begin
            idx  = ramIdx[int'($unsigned($random(seed)) % initWrites)];
            sel  = byteSelT'($random(seed));
            word = $random(seed);
            ramModel[idx] = mergeBytes(ramModel[idx], word, sel);
            writeWord(ramAddr(idx), word, sel);
        end
        for (int i = 0; i < initWrites; i++) begin
            readWord(ramAddr(ramIdx[i]), ramModel[ramIdx[i]]);
        end
        finishTest("ramReadback", failsBefore);

        failsBefore = failCount;
        for (int j = 0; j < wrapWords; j++) begin
            word = $random(seed);
            ramModel[j] = word;
            writeWord(ramAddr(ramWords + j), word, 4'hf);  // one depth past the end
        end
        for (int j = 0; j < wrapWords; j++) begin
            readWord(ramAddr(j), ramModel[j]);
        end
        finishTest("ramWrap", failsBefore);

        failsBefore = failCount;
        for (int i = 0; i < 3; i++) begin
            sel  = (i == 0) ? 4'hf : (i == 1) ? 4'h2 : 4'hc;  // last one hits no led lane
            word = $random(seed);
            newLed = ledWidth'(mergeBytes(busDataT'(expLed), word, sel & 4'b0011));
            writeWord(gpioAddr(4'h0), word, sel);
            expLed <= newLed;
            readWord(gpioAddr(4'h0), busDataT'(newLed));
        end
        readWord(gpioAddr(4'h4), '0);  // hole in the map
        finishTest("ledRegister", failsBefore);

        failsBefore = failCount;
        for (int i = 0; i < inputRounds; i++) begin
            swVal  = ledWidth'($random(seed));
            btnVal = buttonWidth'($random(seed));
            @(posedge HCLK);
            sw      <= swVal;
            buttons <= btnVal;
            repeat (3) @(posedge HCLK);  // two sync flops plus margin
            readWord(gpioAddr(4'h8), busDataT'(swVal));
            readWord(gpioAddr(4'hc), busDataT'(btnVal));
        end
        finishTest("inputRegisters", failsBefore);

        failsBefore = failCount;
        readWord(32'h3000_0000, badData);
        readWord(32'h0000_0100, badData);
        word = $random(seed);
        writeWord({8'h30, 24'(ramIdx[0] * 4)}, word, 4'hf);  // ram offset, wrong region
        writeWord(32'h6000_0000, ~word, 4'hf);               // led offset, wrong region
        readWord(ramAddr(ramIdx[0]), ramModel[ramIdx[0]]);
        readWord(gpioAddr(4'h0), busDataT'(expLed));
        finishTest("unmappedAccess", failsBefore);

        if (timingFails == 0) begin
            testsPassed++;
            $display("test ackTiming: ok over %0d transfers", transfers);
        end else begin
            testsFailed++;
            $display("test ackTiming: %0d errors", timingFails);
        end
        $display("tests: %0d passed, %0d failed, %0d errors", testsPassed, testsFailed,
                 failCount);
        if (failCount == 0 && testsFailed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired after %0d cycles, the run is stuck", watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tests/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int period      = 4,  // ns
    parameter int resetCycles = 3   // cycles with rstN low
) (
    output logic HCLK,
    output logic rstN
);

    initial begin
        HCLK = 1'b0;
        forever #(period / 2) HCLK = ~HCLK;
    end

    initial begin
        rstN <= 1'b0;                        // reset from time zero
        repeat (resetCycles) @(posedge HCLK);
        rstN <= 1'b1;                        // released on a rising edge
    end

endmodule
